// File: mipsDecode_config.svh
`ifndef MIPS_DECODE_CONFIG_SVH
`define MIPS_DECODE_CONFIG_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define CTRL_W      32

// Control word bit positions read back by the ID/EX latch
`define CW_REGDST_LSB   9
`define CW_MEMREAD_BIT  5
`define CW_REGWRITE_BIT 2

// Opcodes
`define OP_RTYPE    6'b000000
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_ADDI     6'b001000
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LB       6'b100000
`define OP_LW       6'b100011
`define OP_SB       6'b101000
`define OP_SW       6'b101011

`define FUNCT_JR    6'b001000
`define HALT_WORD   32'hFFFF_FFFF

`endif

// File: mipsDecodePkg.sv
`include "mipsDecode_config.svh"

package mipsDecodePkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;
    typedef logic [`CTRL_W-1:0]     ctrlWord_t;

    // Control word fields
    typedef logic [5:0] aluOp_t;
    typedef logic [1:0] byteSel_t;    // 11 word, 01 byte
    typedef logic [1:0] memToReg_t;   // 00 ALU, 01 memory, 10 link

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSel_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } brCond_t;

    typedef enum logic [1:0] {
        DST_RT,
        DST_RD,
        DST_RA
    } regDst_t;

endpackage

// File: hazardUnit.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module hazardUnit (
    input  mipsDecodePkg::word_t    i_instruction,
    input  mipsDecodePkg::regAddr_t i_idexRt,
    input  mipsDecodePkg::regAddr_t i_idexRd,
    input  mipsDecodePkg::regAddr_t i_exmemDst,
    input  mipsDecodePkg::regAddr_t i_memwbDst,
    input  mipsDecodePkg::regDst_t  i_idexDst,
    input  logic                    i_idexMemRead,
    input  logic                    i_idexRegWrite,
    input  logic                    i_exmemRegWrite,
    input  logic                    i_exmemMemRead,
    input  logic                    i_memwbRegWrite,
    output logic                    o_stall,
    output logic                    o_pcWrite,
    output logic                    o_ifidWrite,
    output mipsDecodePkg::fwdSel_t  o_fwdSelA,
    output mipsDecodePkg::fwdSel_t  o_fwdSelB,
    output logic                    o_halt
);
    logic [5:0] opcode;
    mipsDecodePkg::regAddr_t rs;
    mipsDecodePkg::regAddr_t rt;
    mipsDecodePkg::regAddr_t idexDstReg;
    logic isBranch;
    logic isJr;
    logic usesRt;
    logic ctrlUse;
    logic idexHit;
    logic exmemHit;
    logic loadUse;
    logic branchStall;
    logic exmemValid;
    logic memwbValid;

    assign opcode   = i_instruction[31:26];
    assign rs       = i_instruction[25:21];
    assign rt       = i_instruction[20:16];
    assign isBranch = (opcode == `OP_BEQ) || (opcode == `OP_BNE);
    assign isJr     = (opcode == `OP_RTYPE) && (i_instruction[5:0] == `FUNCT_JR);
    assign usesRt   = (opcode == `OP_RTYPE) || (opcode == `OP_SW) || (opcode == `OP_SB) || isBranch;
    assign ctrlUse  = isBranch || isJr;   // Resolved in ID, needs operands now

    always_comb begin
        case (i_idexDst)
            mipsDecodePkg::DST_RD: idexDstReg = i_idexRd;
            mipsDecodePkg::DST_RA: idexDstReg = 5'd31;
            default:               idexDstReg = i_idexRt;
        endcase
    end

    // ------------------------------------------------------------
    // Stall detection
    // ------------------------------------------------------------
    assign idexHit  = (idexDstReg != '0) &&
                      ((idexDstReg == rs) || (isBranch && idexDstReg == rt));
    assign exmemHit = (i_exmemDst != '0) &&
                      ((i_exmemDst == rs) || (isBranch && i_exmemDst == rt));

    assign loadUse     = i_idexMemRead && (idexDstReg != '0) &&
                         ((idexDstReg == rs) || (usesRt && idexDstReg == rt));
    assign branchStall = ctrlUse && ((i_idexRegWrite && idexHit) ||
                                     (i_exmemMemRead && exmemHit));

    assign o_stall     = loadUse || branchStall;
    assign o_halt      = (i_instruction == `HALT_WORD);
    assign o_pcWrite   = !o_stall && !o_halt;   // Halt freezes the PC
    assign o_ifidWrite = !o_stall;

    // ------------------------------------------------------------
    // Forward selects, only for operands consumed in ID
    // ------------------------------------------------------------
    assign exmemValid = i_exmemRegWrite && (i_exmemDst != '0);
    assign memwbValid = i_memwbRegWrite && (i_memwbDst != '0);

    always_comb begin
        o_fwdSelA = mipsDecodePkg::FWD_REG;
        o_fwdSelB = mipsDecodePkg::FWD_REG;
        if (ctrlUse && exmemValid && i_exmemDst == rs) o_fwdSelA = mipsDecodePkg::FWD_EXMEM;
        else if (ctrlUse && memwbValid && i_memwbDst == rs) o_fwdSelA = mipsDecodePkg::FWD_MEMWB;
        if (ctrlUse && exmemValid && i_exmemDst == rt) o_fwdSelB = mipsDecodePkg::FWD_EXMEM;
        else if (ctrlUse && memwbValid && i_memwbDst == rt) o_fwdSelB = mipsDecodePkg::FWD_MEMWB;
    end

endmodule

// File: controlUnit.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module controlUnit (
    input  mipsDecodePkg::word_t     i_instruction,
    output mipsDecodePkg::ctrlWord_t o_control,
    output mipsDecodePkg::brCond_t   o_brCond,
    output logic                     o_jump,
    output logic                     o_jumpReg,
    output logic                     o_zeroExtend
);
    logic [5:0] opcode;
    mipsDecodePkg::aluOp_t    aluOp;
    logic                     aluSrc;
    mipsDecodePkg::regDst_t   regDst;
    mipsDecodePkg::byteSel_t  byteSel;
    logic                     memWrite;
    logic                     memRead;
    logic                     regWrite;
    mipsDecodePkg::memToReg_t memToReg;

    assign opcode = i_instruction[31:26];

    always_comb begin
        aluOp        = opcode;   // EX decodes the opcode itself
        aluSrc       = 1'b0;
        regDst       = mipsDecodePkg::DST_RT;
        byteSel      = 2'b00;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        regWrite     = 1'b0;
        memToReg     = 2'b00;
        o_brCond     = mipsDecodePkg::BR_NONE;
        o_jump       = 1'b0;
        o_jumpReg    = 1'b0;
        o_zeroExtend = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                if (i_instruction[5:0] == `FUNCT_JR) begin
                    o_jumpReg = 1'b1;
                end else begin
                    regDst   = mipsDecodePkg::DST_RD;
                    regWrite = 1'b1;
                end
            end
            `OP_LW, `OP_LB: begin
                aluSrc   = 1'b1;
                byteSel  = (opcode == `OP_LW) ? 2'b11 : 2'b01;
                memRead  = 1'b1;
                regWrite = 1'b1;
                memToReg = 2'b01;
            end
            `OP_SW, `OP_SB: begin
                aluSrc   = 1'b1;
                byteSel  = (opcode == `OP_SW) ? 2'b11 : 2'b01;
                memWrite = 1'b1;
            end
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LUI: begin
                aluSrc       = 1'b1;
                regWrite     = 1'b1;
                o_zeroExtend = (opcode != `OP_ADDI);
            end
            `OP_BEQ: o_brCond = mipsDecodePkg::BR_EQ;
            `OP_BNE: o_brCond = mipsDecodePkg::BR_NE;
            `OP_J:   o_jump   = 1'b1;
            `OP_JAL: begin
                o_jump   = 1'b1;
                regDst   = mipsDecodePkg::DST_RA;   // Link into r31
                regWrite = 1'b1;
                memToReg = 2'b10;
            end
            default: aluOp = '0;   // Unsupported, word stays zero
        endcase
    end

    assign o_control = {{(`CTRL_W-18){1'b0}}, aluOp, aluSrc, regDst, byteSel,
                        memWrite, memRead, 2'b00, regWrite, memToReg};

endmodule

// File: registerFile.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module registerFile (
    input  logic                          i_clock,
    input  logic                          i_rst,
    input  logic                          i_flush,
    input  mipsDecodePkg::regAddr_t       i_readReg1,
    input  mipsDecodePkg::regAddr_t       i_readReg2,
    input  mipsDecodePkg::regAddr_t       i_writeReg,
    input  mipsDecodePkg::word_t          i_writeData,
    input  logic                          i_writeEnable,
    output mipsDecodePkg::word_t          o_readData1,
    output mipsDecodePkg::word_t          o_readData2,
    output logic [`REG_COUNT*`DATA_W-1:0] o_regDebug
);
    mipsDecodePkg::word_t regs [`REG_COUNT];

    always_ff @(posedge i_clock) begin
        if (i_rst || i_flush) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_writeEnable && i_writeReg != '0) begin
            regs[i_writeReg] <= i_writeData;
        end
    end

    // No bypass, same-cycle writes reach ID via MEM/WB forward
    assign o_readData1 = (i_readReg1 == '0) ? '0 : regs[i_readReg1];
    assign o_readData2 = (i_readReg2 == '0) ? '0 : regs[i_readReg2];

    for (genvar g = 0; g < `REG_COUNT; g++) begin : genDebug
        assign o_regDebug[g*`DATA_W +: `DATA_W] = regs[g];   // r0 in the low word
    end

endmodule

// File: branchCompare.sv
`timescale 1ns/10ps

module branchCompare (
    input  mipsDecodePkg::word_t   i_operandA,
    input  mipsDecodePkg::word_t   i_operandB,
    input  mipsDecodePkg::brCond_t i_brCond,
    output logic                   o_taken
);
    logic equal;

    assign equal = (i_operandA == i_operandB);

    always_comb begin
        case (i_brCond)
            mipsDecodePkg::BR_EQ: o_taken = equal;
            mipsDecodePkg::BR_NE: o_taken = !equal;
            default:              o_taken = 1'b0;
        endcase
    end

endmodule

// File: idStage.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module idStage (
    input  logic                          i_clock,
    input  logic                          i_rst,
    input  logic                          i_flush,
    input  mipsDecodePkg::word_t          i_instruction,
    input  mipsDecodePkg::word_t          i_pcNext,
    input  mipsDecodePkg::word_t          i_writeData,
    input  mipsDecodePkg::word_t          i_exmemData,
    input  mipsDecodePkg::regAddr_t       i_writeReg,
    input  mipsDecodePkg::regAddr_t       i_exmemDst,
    input  mipsDecodePkg::regAddr_t       i_idexRt,
    input  mipsDecodePkg::regAddr_t       i_idexRd,
    input  logic                          i_writeEnable,
    input  logic                          i_exmemRegWrite,
    input  logic                          i_exmemMemRead,
    input  logic                          i_idexMemRead,
    input  logic                          i_idexRegWrite,
    input  mipsDecodePkg::regDst_t        i_idexDst,
    output mipsDecodePkg::word_t          o_readData1,
    output mipsDecodePkg::word_t          o_readData2,
    output mipsDecodePkg::word_t          o_immediate,
    output mipsDecodePkg::word_t          o_jumpTarget,
    output mipsDecodePkg::ctrlWord_t      o_control,
    output logic                          o_pcWrite,
    output logic                          o_ifidWrite,
    output logic                          o_flushIf,
    output logic                          o_branchTaken,
    output logic                          o_jump,
    output logic                          o_halt,
    output logic [`REG_COUNT*`DATA_W-1:0] o_regDebug
);
    mipsDecodePkg::word_t     rfData1;
    mipsDecodePkg::word_t     rfData2;
    mipsDecodePkg::ctrlWord_t ctrlRaw;
    mipsDecodePkg::brCond_t   brCond;
    mipsDecodePkg::fwdSel_t   fwdSelA;
    mipsDecodePkg::fwdSel_t   fwdSelB;
    logic jumpOp;
    logic jumpReg;
    logic zeroExtend;
    logic stall;
    logic taken;

    function automatic mipsDecodePkg::word_t fwdMux(input mipsDecodePkg::fwdSel_t sel,
                                                    input mipsDecodePkg::word_t rf,
                                                    input mipsDecodePkg::word_t exmem,
                                                    input mipsDecodePkg::word_t memwb);
        case (sel)
            mipsDecodePkg::FWD_EXMEM: return exmem;
            mipsDecodePkg::FWD_MEMWB: return memwb;
            default:                  return rf;
        endcase
    endfunction

    hazardUnit uHazard (
        .i_instruction(i_instruction), .i_idexRt(i_idexRt), .i_idexRd(i_idexRd),
        .i_exmemDst(i_exmemDst), .i_memwbDst(i_writeReg), .i_idexDst(i_idexDst),
        .i_idexMemRead(i_idexMemRead), .i_idexRegWrite(i_idexRegWrite),
        .i_exmemRegWrite(i_exmemRegWrite), .i_exmemMemRead(i_exmemMemRead),
        .i_memwbRegWrite(i_writeEnable), .o_stall(stall), .o_pcWrite(o_pcWrite),
        .o_ifidWrite(o_ifidWrite), .o_fwdSelA(fwdSelA), .o_fwdSelB(fwdSelB), .o_halt(o_halt)
    );

    controlUnit uControl (
        .i_instruction(i_instruction), .o_control(ctrlRaw), .o_brCond(brCond),
        .o_jump(jumpOp), .o_jumpReg(jumpReg), .o_zeroExtend(zeroExtend)
    );

    registerFile uRegs (
        .i_clock(i_clock), .i_rst(i_rst), .i_flush(i_flush),
        .i_readReg1(i_instruction[25:21]), .i_readReg2(i_instruction[20:16]),
        .i_writeReg(i_writeReg), .i_writeData(i_writeData), .i_writeEnable(i_writeEnable),
        .o_readData1(rfData1), .o_readData2(rfData2), .o_regDebug(o_regDebug)
    );

    branchCompare uCompare (
        .i_operandA(o_readData1), .i_operandB(o_readData2), .i_brCond(brCond), .o_taken(taken)
    );

    // ------------------------------------------------------------
    // Operands and immediate
    // ------------------------------------------------------------
    assign o_readData1 = fwdMux(fwdSelA, rfData1, i_exmemData, i_writeData);
    assign o_readData2 = fwdMux(fwdSelB, rfData2, i_exmemData, i_writeData);
    assign o_immediate = zeroExtend ? {16'b0, i_instruction[15:0]}
                                    : {{16{i_instruction[15]}}, i_instruction[15:0]};

    // ------------------------------------------------------------
    // Early branch and jump resolution
    // ------------------------------------------------------------
    assign o_jumpTarget  = jumpReg ? o_readData1
                                   : {i_pcNext[31:28], i_instruction[25:0], 2'b00};
    assign o_branchTaken = taken && !stall;
    assign o_jump        = (jumpOp || jumpReg) && !stall;
    assign o_flushIf     = o_branchTaken || o_jump;   // Squash the fetched slot
    assign o_control     = stall ? '0 : ctrlRaw;       // Bubble into ID/EX

endmodule

// File: idexLatch.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module idexLatch (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic                     i_flush,
    input  mipsDecodePkg::ctrlWord_t i_control,
    input  mipsDecodePkg::word_t     i_readData1,
    input  mipsDecodePkg::word_t     i_readData2,
    input  mipsDecodePkg::word_t     i_immediate,
    input  mipsDecodePkg::word_t     i_instruction,
    output mipsDecodePkg::ctrlWord_t o_control,
    output mipsDecodePkg::word_t     o_readData1,
    output mipsDecodePkg::word_t     o_readData2,
    output mipsDecodePkg::word_t     o_immediate,
    output mipsDecodePkg::word_t     o_instruction,
    output mipsDecodePkg::regAddr_t  o_rt,
    output mipsDecodePkg::regAddr_t  o_rd,
    output logic                     o_memRead,
    output logic                     o_regWrite,
    output mipsDecodePkg::regDst_t   o_regDst
);
    always_ff @(posedge i_clock) begin
        if (i_rst || i_flush) begin
            o_control     <= '0;
            o_readData1   <= '0;
            o_readData2   <= '0;
            o_immediate   <= '0;
            o_instruction <= '0;
        end else begin
            o_control     <= i_control;
            o_readData1   <= i_readData1;
            o_readData2   <= i_readData2;
            o_immediate   <= i_immediate;
            o_instruction <= i_instruction;
        end
    end

    // Fields fed back to hazard detection
    assign o_rt       = o_instruction[20:16];
    assign o_rd       = o_instruction[15:11];
    assign o_memRead  = o_control[`CW_MEMREAD_BIT];
    assign o_regWrite = o_control[`CW_REGWRITE_BIT];
    assign o_regDst   = mipsDecodePkg::regDst_t'(o_control[`CW_REGDST_LSB +: 2]);

endmodule

// File: mipsDecode.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module mipsDecode (
    input  logic                          i_clock,
    input  logic                          i_rst,
    input  logic                          i_flush,
    input  mipsDecodePkg::word_t          i_instruction,
    input  mipsDecodePkg::word_t          i_pcNext,
    input  logic                          i_writeEnable,
    input  mipsDecodePkg::regAddr_t       i_writeReg,
    input  mipsDecodePkg::word_t          i_writeData,
    input  logic                          i_exmemRegWrite,
    input  logic                          i_exmemMemRead,
    input  mipsDecodePkg::regAddr_t       i_exmemDst,
    input  mipsDecodePkg::word_t          i_exmemData,
    output logic                          o_pcWrite,
    output logic                          o_ifidWrite,
    output logic                          o_flushIf,
    output logic                          o_branchTaken,
    output logic                          o_jump,
    output mipsDecodePkg::word_t          o_jumpTarget,
    output logic                          o_halt,
    output logic [`REG_COUNT*`DATA_W-1:0] o_regDebug,
    output mipsDecodePkg::ctrlWord_t      o_exControl,
    output mipsDecodePkg::word_t          o_exReadData1,
    output mipsDecodePkg::word_t          o_exReadData2,
    output mipsDecodePkg::word_t          o_exImmediate,
    output mipsDecodePkg::word_t          o_exInstruction
);
    mipsDecodePkg::ctrlWord_t idControl;
    mipsDecodePkg::word_t     idData1;
    mipsDecodePkg::word_t     idData2;
    mipsDecodePkg::word_t     idImmediate;
    mipsDecodePkg::regAddr_t  exRt;
    mipsDecodePkg::regAddr_t  exRd;
    mipsDecodePkg::regDst_t   exRegDst;
    logic                     exMemRead;
    logic                     exRegWrite;

    idStage uId (
        .i_clock(i_clock), .i_rst(i_rst), .i_flush(i_flush),
        .i_instruction(i_instruction), .i_pcNext(i_pcNext),
        .i_writeData(i_writeData), .i_exmemData(i_exmemData),
        .i_writeReg(i_writeReg), .i_exmemDst(i_exmemDst),
        .i_idexRt(exRt), .i_idexRd(exRd),    // Latch state back to hazard checks
        .i_writeEnable(i_writeEnable), .i_exmemRegWrite(i_exmemRegWrite),
        .i_exmemMemRead(i_exmemMemRead), .i_idexMemRead(exMemRead),
        .i_idexRegWrite(exRegWrite), .i_idexDst(exRegDst),
        .o_readData1(idData1), .o_readData2(idData2), .o_immediate(idImmediate),
        .o_jumpTarget(o_jumpTarget), .o_control(idControl),
        .o_pcWrite(o_pcWrite), .o_ifidWrite(o_ifidWrite), .o_flushIf(o_flushIf),
        .o_branchTaken(o_branchTaken), .o_jump(o_jump), .o_halt(o_halt),
        .o_regDebug(o_regDebug)
    );

    idexLatch uIdex (
        .i_clock(i_clock), .i_rst(i_rst), .i_flush(i_flush),
        .i_control(idControl), .i_readData1(idData1), .i_readData2(idData2),
        .i_immediate(idImmediate), .i_instruction(i_instruction),
        .o_control(o_exControl), .o_readData1(o_exReadData1),
        .o_readData2(o_exReadData2), .o_immediate(o_exImmediate),
        .o_instruction(o_exInstruction), .o_rt(exRt), .o_rd(exRd),
        .o_memRead(exMemRead), .o_regWrite(exRegWrite), .o_regDst(exRegDst)
    );

endmodule

// File: mipsDecode_assertions.sv
`timescale 1ns/10ps

module mipsDecodeAssertions (
    input logic                     i_clock,
    input logic                     i_rst,
    input logic                     i_pcWrite,
    input logic                     i_ifidWrite,
    input logic                     i_flushIf,
    input mipsDecodePkg::ctrlWord_t i_idControl,
    input mipsDecodePkg::ctrlWord_t i_exControl
);
    // IF/ID hold is the stall indicator visible at the top
    // The bubble must also land in ID/EX one edge later
    property stallFreezesFront;
        @(posedge i_clock) disable iff (i_rst)
        !i_ifidWrite |-> (!i_pcWrite && i_idControl == '0) ##1 (i_exControl == '0);
    endproperty

    property noFlushOnStall;
        @(posedge i_clock) disable iff (i_rst)
        !i_ifidWrite |-> !i_flushIf;
    endproperty

    property resetClearsLatch;
        @(posedge i_clock) i_rst |=> (i_exControl == '0);
    endproperty

    assert property (stallFreezesFront) else $error("stall left PC or control word active");
    assert property (noFlushOnStall) else $error("IF flush raised during a stall");
    assert property (resetClearsLatch) else $error("ID/EX control not cleared after reset");

endmodule

bind mipsDecode mipsDecodeAssertions uAssertions (
    .i_clock(i_clock), .i_rst(i_rst), .i_pcWrite(o_pcWrite), .i_ifidWrite(o_ifidWrite),
    .i_flushIf(o_flushIf), .i_idControl(idControl), .i_exControl(o_exControl)
);

// File: mipsDecodeTb.sv
`timescale 1ns/10ps
`include "mipsDecode_config.svh"

module mipsDecodeTb;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_CYCLES   = 2000;
    localparam int          MAX_CYCLES   = RESET_CYCLES + NUM_CYCLES + 100;
    localparam logic [31:0] SEED         = 32'h3fe125c7;

    logic clock = 1'b0;
    logic rst, flush, writeEnable, exmemRegWrite, exmemMemRead;
    mipsDecodePkg::word_t    instruction, pcNext, writeData, exmemData;
    mipsDecodePkg::regAddr_t writeReg, exmemDst;
    logic pcWrite, ifidWrite, flushIf, branchTaken, jump, halt;
    mipsDecodePkg::word_t     jumpTarget, exReadData1, exReadData2, exImmediate, exInstruction;
    mipsDecodePkg::ctrlWord_t exControl;
    logic [`REG_COUNT*`DATA_W-1:0] regDebug;

    // Reference model state
    mipsDecodePkg::word_t     regModel [`REG_COUNT];
    mipsDecodePkg::ctrlWord_t expExControl;
    mipsDecodePkg::word_t     expExData1, expExData2, expExImmediate, expExInstruction;
    mipsDecodePkg::regAddr_t  idexDst;
    logic idexMemRead, idexRegWrite;
    int errors = 0;
    int checks = 0;
    int cycleCount = 0;
    int unsigned seedValue;

    mipsDecode dut (
        .i_clock(clock), .i_rst(rst), .i_flush(flush), .i_instruction(instruction),
        .i_pcNext(pcNext), .i_writeEnable(writeEnable), .i_writeReg(writeReg),
        .i_writeData(writeData), .i_exmemRegWrite(exmemRegWrite),
        .i_exmemMemRead(exmemMemRead), .i_exmemDst(exmemDst), .i_exmemData(exmemData),
        .o_pcWrite(pcWrite), .o_ifidWrite(ifidWrite), .o_flushIf(flushIf),
        .o_branchTaken(branchTaken), .o_jump(jump), .o_jumpTarget(jumpTarget),
        .o_halt(halt), .o_regDebug(regDebug), .o_exControl(exControl),
        .o_exReadData1(exReadData1), .o_exReadData2(exReadData2),
        .o_exImmediate(exImmediate), .o_exInstruction(exInstruction)
    );

    always #50 clock = ~clock;   // 100 ns period

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: actual %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic mipsDecodePkg::ctrlWord_t packControl(
        input logic [5:0] aluOp, input logic aluSrc, input logic [1:0] regDst,
        input logic [1:0] byteSel, input logic memWrite, input logic memRead,
        input logic regWrite, input logic [1:0] memToReg);
        return {14'b0, aluOp, aluSrc, regDst, byteSel, memWrite, memRead, 2'b00,
                regWrite, memToReg};
    endfunction

    // ------------------------------------------------------------
    // Decode table of the model
    // ------------------------------------------------------------
    function automatic mipsDecodePkg::ctrlWord_t expectedControl(input mipsDecodePkg::word_t w);
        logic [5:0] op;
        op = w[31:26];
        case (op)
            `OP_RTYPE: begin
                if (w[5:0] == `FUNCT_JR) return '0;
                return packControl(op, 1'b0, 2'd1, 2'b00, 1'b0, 1'b0, 1'b1, 2'b00);
            end
            `OP_LW:  return packControl(op, 1'b1, 2'd0, 2'b11, 1'b0, 1'b1, 1'b1, 2'b01);
            `OP_LB:  return packControl(op, 1'b1, 2'd0, 2'b01, 1'b0, 1'b1, 1'b1, 2'b01);
            `OP_SW:  return packControl(op, 1'b1, 2'd0, 2'b11, 1'b1, 1'b0, 1'b0, 2'b00);
            `OP_SB:  return packControl(op, 1'b1, 2'd0, 2'b01, 1'b1, 1'b0, 1'b0, 2'b00);
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LUI:
                return packControl(op, 1'b1, 2'd0, 2'b00, 1'b0, 1'b0, 1'b1, 2'b00);
            `OP_BEQ, `OP_BNE, `OP_J:
                return packControl(op, 1'b0, 2'd0, 2'b00, 1'b0, 1'b0, 1'b0, 2'b00);
            `OP_JAL: return packControl(op, 1'b0, 2'd2, 2'b00, 1'b0, 1'b0, 1'b1, 2'b10);
            default: return '0;
        endcase
    endfunction

    // Branch and jr priority EX/MEM, then MEM/WB, then register file
    function automatic mipsDecodePkg::word_t forwardOperand(input mipsDecodePkg::regAddr_t src,
                                                            input logic useForward);
        if (useForward && exmemRegWrite && exmemDst != 0 && exmemDst == src) return exmemData;
        if (useForward && writeEnable && writeReg != 0 && writeReg == src) return writeData;
        return regModel[src];
    endfunction

    // Small register range keeps hazards frequent
    function automatic mipsDecodePkg::word_t randomInstruction();
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        logic [31:0] bits;
        logic [5:0]  op;
        rs   = 5'($urandom_range(0, 3));
        rt   = 5'($urandom_range(0, 3));
        rd   = 5'($urandom_range(0, 3));
        imm  = 16'($urandom());
        bits = $urandom();
        case ($urandom_range(0, 15))
            0, 1:    return {`OP_RTYPE, rs, rt, rd, 5'd0, 6'(6'h20 + $urandom_range(0, 7))};
            2:       return {`OP_RTYPE, rs, 15'd0, `FUNCT_JR};
            3, 15:   return {`OP_LW, rs, rt, imm};
            4:       return {`OP_LB, rs, rt, imm};
            5:       return {`OP_SW, rs, rt, imm};
            6:       return {`OP_SB, rs, rt, imm};
            7:       return {`OP_ADDI, rs, rt, imm};
            8:       return {`OP_ANDI, rs, rt, imm};
            9:       return {bits[0] ? `OP_ORI : `OP_LUI, rs, rt, imm};
            10:      return {`OP_BEQ, rs, rt, imm};
            11:      return {`OP_BNE, rs, rt, imm};
            12:      return {bits[31] ? `OP_JAL : `OP_J, bits[25:0]};
            13:      return `HALT_WORD;
            default: begin
                op = 6'(6'h30 + $urandom_range(0, 14));   // Unsupported opcodes
                return {op, bits[25:0]};
            end
        endcase
    endfunction

    task automatic driveInputs();
        rst           = 1'b0;
        instruction   = randomInstruction();
        pcNext        = $urandom();
        writeEnable   = 1'($urandom_range(0, 1));
        writeReg      = 5'($urandom_range(0, 3));
        writeData     = $urandom();
        exmemRegWrite = 1'($urandom_range(0, 1));
        exmemMemRead  = 1'($urandom_range(0, 1));
        exmemDst      = 5'($urandom_range(0, 3));
        exmemData     = $urandom();
        flush         = ($urandom_range(0, 63) == 0);
    endtask

    task automatic checkLatch();
        checkValue("o_exControl", exControl, expExControl);
        checkValue("o_exReadData1", exReadData1, expExData1);
        checkValue("o_exReadData2", exReadData2, expExData2);
        checkValue("o_exImmediate", exImmediate, expExImmediate);
        checkValue("o_exInstruction", exInstruction, expExInstruction);
        for (int r = 0; r < `REG_COUNT; r++) begin
            checkValue($sformatf("o_regDebug[r%0d]", r), regDebug[r*`DATA_W +: `DATA_W],
                       regModel[r]);
        end
    endtask

    // ------------------------------------------------------------
    // Combinational checks, then the model's rising edge
    // ------------------------------------------------------------
    task automatic checkAndAdvance();
        mipsDecodePkg::word_t     opA, opB, imm, target;
        mipsDecodePkg::ctrlWord_t ctrl;
        mipsDecodePkg::regAddr_t  rs, rt;
        logic [5:0] op;
        logic isBr, isJr, ctrlUse, usesRt, stall, taken, doJump;
        op      = instruction[31:26];
        rs      = instruction[25:21];
        rt      = instruction[20:16];
        isBr    = (op == `OP_BEQ) || (op == `OP_BNE);
        isJr    = (op == `OP_RTYPE) && (instruction[5:0] == `FUNCT_JR);
        ctrlUse = isBr || isJr;
        usesRt  = (op == `OP_RTYPE) || (op == `OP_SW) || (op == `OP_SB) || isBr;
        stall   = idexMemRead && idexDst != 0 && (idexDst == rs || (usesRt && idexDst == rt));
        if (ctrlUse && idexRegWrite && idexDst != 0 &&
            (idexDst == rs || (isBr && idexDst == rt))) stall = 1'b1;
        if (ctrlUse && exmemMemRead && exmemDst != 0 &&
            (exmemDst == rs || (isBr && exmemDst == rt))) stall = 1'b1;
        opA    = forwardOperand(rs, ctrlUse);
        opB    = forwardOperand(rt, ctrlUse);
        taken  = !stall && ((op == `OP_BEQ && opA == opB) || (op == `OP_BNE && opA != opB));
        doJump = !stall && (op == `OP_J || op == `OP_JAL || isJr);
        target = isJr ? opA : {pcNext[31:28], instruction[25:0], 2'b00};
        imm    = (op == `OP_ANDI || op == `OP_ORI || op == `OP_LUI) ?
                 {16'b0, instruction[15:0]} : {{16{instruction[15]}}, instruction[15:0]};
        ctrl   = stall ? '0 : expectedControl(instruction);

        checkValue("o_pcWrite", pcWrite, !stall && instruction != `HALT_WORD);
        checkValue("o_ifidWrite", ifidWrite, !stall);
        checkValue("o_branchTaken", branchTaken, taken);
        checkValue("o_jump", jump, doJump);
        checkValue("o_flushIf", flushIf, taken || doJump);
        checkValue("o_jumpTarget", jumpTarget, target);
        checkValue("o_halt", halt, instruction == `HALT_WORD);

        if (flush) begin   // Clears registers and ID/EX
            for (int r = 0; r < `REG_COUNT; r++) regModel[r] = '0;
            {expExControl, expExData1, expExData2, expExImmediate, expExInstruction} = '0;
        end else begin
            expExControl     = ctrl;
            expExData1       = opA;
            expExData2       = opB;
            expExImmediate   = imm;
            expExInstruction = instruction;
            if (writeEnable && writeReg != 0) regModel[writeReg] = writeData;
        end
        idexMemRead  = expExControl[5];
        idexRegWrite = expExControl[2];
        case (expExControl[10:9])
            2'd1:    idexDst = expExInstruction[15:11];
            2'd2:    idexDst = 5'd31;
            default: idexDst = expExInstruction[20:16];
        endcase
    endtask

    initial begin
        seedValue = $urandom(SEED);
        {rst, flush, writeEnable, exmemRegWrite, exmemMemRead} = 5'b10000;
        {instruction, pcNext, writeData, exmemData} = '0;
        {writeReg, exmemDst} = '0;
        for (int r = 0; r < `REG_COUNT; r++) regModel[r] = '0;
        {expExControl, expExData1, expExData2, expExImmediate, expExInstruction} = '0;
        {idexDst, idexMemRead, idexRegWrite} = '0;

        repeat (RESET_CYCLES) @(negedge clock);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            if (i > 0) @(negedge clock);
            checkLatch();
            driveInputs();
            #10;   // Let the decode paths settle
            checkAndAdvance();
        end
        @(negedge clock);
        checkLatch();

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: mipsDecode.f
+incdir+.
mipsDecodePkg.sv
hazardUnit.sv
controlUnit.sv
registerFile.sv
branchCompare.sv
idStage.sv
idexLatch.sv
mipsDecode.sv
mipsDecode_assertions.sv
mipsDecodeTb.sv
